//--- Makefile
VERILATOR ?= verilator
TOP       ?= montmul_tb
FILELIST  ?= montmul.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- montmul.f
src/montmul_pkg.sv
src/montmul_ctrl.sv
src/montmul_multiples.sv
src/montmul_digit_select.sv
src/montmul_accumulator.sv
src/montmul_top.sv
verification/montmul_tb.sv

//--- src/montmul_accumulator.sv
module montmul_accumulator import montmul_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  ctrl_bus_t  ctrl,
    input  acc_t       addend,
    output logic [1:0] acc_low,
    output logic       sub_negative,
    output operand_t   result
);

    acc_t     acc_q;
    acc_t     acc_d;
    acc_t     sum;
    acc_t     diff;
    operand_t result_q;

    assign sum  = acc_q + addend;
    // trial difference for the final reduction
    assign diff = acc_q - addend;

    // top bit is the sign since acc stays below 2m
    assign sub_negative = diff[acc_width-1];

    always_comb begin
        acc_d = acc_q;
        unique case (ctrl.acc_op)
            acc_clear: begin
                acc_d = '0;
            end
            acc_add: begin
                acc_d = sum;
            end
            acc_add_shift: begin
                // low two bits of sum are zero here by choice of the M digit
                acc_d = sum >> 2;
            end
            acc_sub_m: begin
                if (!sub_negative) begin
                    acc_d = diff;
                end
            end
            default: begin
                acc_d = acc_q;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_d;
        end
    end

    // fully reduced value fits in op_width bits
    always_ff @(posedge clk) begin
        if (ctrl.result_en) begin
            result_q <= acc_q[op_width-1:0];
        end
    end

    assign acc_low = acc_q[1:0];
    assign result  = result_q;

endmodule

//--- src/montmul_ctrl.sv
module montmul_ctrl import montmul_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    input  logic      sub_negative,
    output ctrl_bus_t ctrl,
    output logic      busy,
    output logic      done
);

    ctrl_state_e               state_q;
    ctrl_state_e               state_d;
    logic [iter_cnt_width-1:0] iter_q;
    logic                      last_iter;
    logic                      done_q;

    // the current pair is the final one
    assign last_iter = (iter_q == iter_cnt_width'(iter_count - 1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // one count per B/M pair
    always_ff @(posedge clk) begin
        if (!resetn) begin
            iter_q <= '0;
        end else if (state_q == st_idle) begin
            iter_q <= '0;
        end else if (state_q == st_add_m) begin
            iter_q <= iter_q + 1'b1;
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle: begin
                if (start) begin
                    state_d = st_prep_m;
                end
            end
            st_prep_m: state_d = st_prep_b;
            st_prep_b: state_d = st_add_b;
            st_add_b:  state_d = st_add_m;
            st_add_m: begin
                if (last_iter) begin
                    state_d = st_reduce;
                end else begin
                    state_d = st_add_b;
                end
            end
            st_reduce: begin
                // stay until the trial difference goes negative
                if (sub_negative) begin
                    state_d = st_done;
                end
            end
            st_done:   state_d = st_idle;
            default:   state_d = st_idle;
        endcase
    end

    // datapath controls
    always_comb begin
        ctrl = ctrl_idle;
        unique case (state_q)
            st_idle: begin
                if (start) begin
                    ctrl.acc_op = acc_clear;
                    ctrl.load_a = 1'b1;
                end
            end
            st_prep_m: begin
                ctrl.prep_m = 1'b1;
            end
            st_prep_b: begin
                ctrl.prep_b = 1'b1;
            end
            st_add_b: begin
                ctrl.acc_op = acc_add;
            end
            st_add_m: begin
                ctrl.acc_op  = acc_add_shift;
                ctrl.phase_m = 1'b1;
                ctrl.shift_a = 1'b1;
            end
            st_reduce: begin
                // accumulator drops the difference once it is negative
                ctrl.acc_op = acc_sub_m;
            end
            st_done: begin
                ctrl.result_en = 1'b1;
            end
            default: begin
                ctrl = ctrl_idle;
            end
        endcase
    end

    // done follows the result register update by the same edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= (state_q == st_done);
        end
    end

    assign done = done_q;
    assign busy = (state_q != st_idle);

endmodule

//--- src/montmul_digit_select.sv
module montmul_digit_select import montmul_pkg::*; (
    input  logic       clk,
    input  ctrl_bus_t  ctrl,
    input  operand_t   a,
    input  operand_t   b,
    input  operand_t   m,
    input  multiples_t mult,
    input  logic [1:0] acc_low,
    output acc_t       addend
);

    operand_t  a_q;
    mult_sel_e sel;

    // copy of a, two bits consumed per iteration
    always_ff @(posedge clk) begin
        if (ctrl.load_a) begin
            a_q <= a;
        end else if (ctrl.shift_a) begin
            a_q <= a_q >> 2;
        end
    end

    always_comb begin
        sel = sel_zero;
        if (ctrl.acc_op == acc_sub_m) begin
            // final reduction subtracts plain m
            sel = sel_m;
        end else if (ctrl.phase_m) begin
            // pick q so that acc + q*m is a multiple of four
            unique case ({acc_low, m[1:0]})
                4'b01_01, 4'b11_11: sel = sel_3m;
                4'b10_01, 4'b10_11: sel = sel_2m;
                4'b11_01, 4'b01_11: sel = sel_m;
                default:            sel = sel_zero;
            endcase
        end else begin
            unique case (a_q[1:0])
                2'b01:   sel = sel_b;
                2'b10:   sel = sel_2b;
                2'b11:   sel = sel_3b;
                default: sel = sel_zero;
            endcase
        end
    end

    always_comb begin
        unique case (sel)
            sel_b:   addend = acc_t'(b);
            sel_2b:  addend = acc_t'(b) << 1;
            sel_3b:  addend = mult.three_b;
            sel_m:   addend = acc_t'(m);
            sel_2m:  addend = acc_t'(m) << 1;
            sel_3m:  addend = mult.three_m;
            default: addend = '0;
        endcase
    end

endmodule

//--- src/montmul_multiples.sv
module montmul_multiples import montmul_pkg::*; (
    input  logic       clk,
    input  ctrl_bus_t  ctrl,
    input  operand_t   b,
    input  operand_t   m,
    output multiples_t mult
);

    acc_t src;
    acc_t triple;
    acc_t three_b_q;
    acc_t three_m_q;

    // m first, then b, through the same adder
    always_comb begin
        if (ctrl.prep_m) begin
            src = acc_t'(m);
        end else begin
            src = acc_t'(b);
        end
    end

    // x + 2x
    assign triple = src + (src << 1);

    always_ff @(posedge clk) begin
        if (ctrl.prep_m) begin
            three_m_q <= triple;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.prep_b) begin
            three_b_q <= triple;
        end
    end

    assign mult.three_b = three_b_q;
    assign mult.three_m = three_m_q;

endmodule

//--- src/montmul_pkg.sv
package montmul_pkg;

    // operand and datapath widths
    localparam int op_width = 1024;
    // room for the shifted accumulator plus 3B and 3M, and a sign bit
    localparam int acc_width = op_width + 3;
    // two bits of a are consumed per iteration
    localparam int iter_count = op_width / 2;
    localparam int iter_cnt_width = $clog2(iter_count + 1);

    typedef logic [op_width-1:0] operand_t;
    typedef logic [acc_width-1:0] acc_t;

    typedef enum logic [2:0] {
        st_idle,
        st_prep_m,
        st_prep_b,
        st_add_b,
        st_add_m,
        st_reduce,
        st_done
    } ctrl_state_e;

    // multiple select codes
    typedef enum logic [2:0] {
        sel_zero = 3'd0,
        sel_b    = 3'd1,
        sel_2b   = 3'd2,
        sel_3b   = 3'd3,
        sel_m    = 3'd4,
        sel_2m   = 3'd5,
        sel_3m   = 3'd6
    } mult_sel_e;

    typedef enum logic [2:0] {
        acc_hold,
        acc_clear,
        acc_add,
        acc_add_shift,
        acc_sub_m
    } acc_op_e;

    typedef struct packed {
        acc_op_e acc_op;
        logic    load_a;
        logic    shift_a;
        logic    prep_m;
        logic    prep_b;
        logic    phase_m;
        logic    result_en;
    } ctrl_bus_t;

    typedef struct packed {
        acc_t three_b;
        acc_t three_m;
    } multiples_t;

    // controller outputs when nothing is happening
    localparam ctrl_bus_t ctrl_idle = '{
        acc_op:    acc_hold,
        load_a:    1'b0,
        shift_a:   1'b0,
        prep_m:    1'b0,
        prep_b:    1'b0,
        phase_m:   1'b0,
        result_en: 1'b0
    };

endpackage

//--- src/montmul_top.sv
module montmul_top import montmul_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    input  operand_t m,
    output operand_t result,
    output logic     busy,
    output logic     done
);

    ctrl_bus_t  ctrl;
    multiples_t mult;
    acc_t       addend;
    logic [1:0] acc_low;
    logic       sub_negative;

    montmul_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .sub_negative (sub_negative),
        .ctrl         (ctrl),
        .busy         (busy),
        .done         (done)
    );

    // 3B and 3M, formed once per operation
    montmul_multiples u_multiples (
        .clk  (clk),
        .ctrl (ctrl),
        .b    (b),
        .m    (m),
        .mult (mult)
    );

    montmul_digit_select u_digit_select (
        .clk     (clk),
        .ctrl    (ctrl),
        .a       (a),
        .b       (b),
        .m       (m),
        .mult    (mult),
        .acc_low (acc_low),
        .addend  (addend)
    );

    montmul_accumulator u_accumulator (
        .clk          (clk),
        .resetn       (resetn),
        .ctrl         (ctrl),
        .addend       (addend),
        .acc_low      (acc_low),
        .sub_negative (sub_negative),
        .result       (result)
    );

endmodule

//--- verification/montmul_tb.sv
module montmul_tb import montmul_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 40;
    localparam int done_timeout = 4 * op_width;
    // prep, loop, up to two reduction cycles, st_done and the done cycle
    localparam int max_latency  = 2 + 2 * iter_count + 4;

    logic        clk;
    logic        resetn;
    logic        start;
    operand_t    a;
    operand_t    b;
    operand_t    m;
    operand_t    result;
    logic        busy;
    logic        done;
    logic [31:0] lfsr_q;
    int          errors;
    int          checks;
    int          tests;

    montmul_top u_montmul_top (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_operand(output operand_t v);
        for (int i = 0; i < op_width; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[i] = lfsr_q[0];
        end
    endtask

    // odd modulus, operands below it
    task automatic random_case(output operand_t ra, output operand_t rb, output operand_t rm);
        random_operand(rm);
        rm[0] = 1'b1;
        random_operand(ra);
        random_operand(rb);
        ra = ra % rm;
        rb = rb % rm;
    endtask

    // bit-serial montgomery, one halving per bit of a
    function automatic operand_t mont_model(input operand_t ma, input operand_t mb,
                                            input operand_t mm);
        logic [op_width+1:0] s;
        s = '0;
        for (int i = 0; i < op_width; i++) begin
            if (ma[i]) begin
                s = s + mb;
            end
            if (s[0]) begin
                s = s + mm;
            end
            s = s >> 1;
        end
        if (s >= mm) begin
            s = s - mm;
        end
        return s[op_width-1:0];
    endfunction

    task automatic check_result(input string name, input operand_t exp, input operand_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic start_op(input operand_t oa, input operand_t ob, input operand_t om);
        @(posedge clk);
        a     <= oa;
        b     <= ob;
        m     <= om;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // busy must stay high until the done cycle, where it drops
    task automatic wait_done(input string name, output bit seen, output int cycles);
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < done_timeout) begin
            @(negedge clk);
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
                check_bit({name, " busy at done"}, 1'b0, busy);
            end else begin
                check_bit({name, " busy"}, 1'b1, busy);
            end
        end
        if (!seen) begin
            errors++;
            $display("%s: no done pulse within %0d cycles", name, done_timeout);
        end
    endtask

    // done is a single pulse
    task automatic check_quiet(input string name, input int n);
        repeat (n) begin
            @(negedge clk);
            check_bit({name, " extra done"}, 1'b0, done);
        end
    endtask

    task automatic run_op(input string name, input operand_t oa, input operand_t ob,
                          input operand_t om);
        bit seen;
        int cycles;
        start_op(oa, ob, om);
        wait_done(name, seen, cycles);
        if (seen) begin
            check_result(name, mont_model(oa, ob, om), result);
            check_quiet(name, 4);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_small();
        int e0;
        e0 = errors;
        run_op("test_small", operand_t'(3), operand_t'(5), operand_t'(7));
        check_bit("test_small below m", 1'b1, result < operand_t'(7));
        finish_test("test_small", e0);
    endtask

    task automatic test_zero();
        int       e0;
        operand_t ra;
        operand_t rb;
        operand_t rm;
        e0 = errors;
        random_case(ra, rb, rm);
        run_op("test_zero", '0, rb, rm);
        check_result("test_zero", '0, result);
        finish_test("test_zero", e0);
    endtask

    task automatic test_random();
        int       e0;
        operand_t ra;
        operand_t rb;
        operand_t rm;
        e0 = errors;
        repeat (8) begin
            random_case(ra, rb, rm);
            run_op("test_random", ra, rb, rm);
        end
        finish_test("test_random", e0);
    endtask

    task automatic test_busy_ignore();
        int       e0;
        bit       seen;
        int       cycles;
        operand_t ra;
        operand_t rb;
        operand_t rm;
        e0 = errors;
        random_case(ra, rb, rm);
        start_op(ra, rb, rm);
        repeat (50) begin
            @(negedge clk);
            check_bit("test_busy_ignore busy", 1'b1, busy);
            check_bit("test_busy_ignore done", 1'b0, done);
        end
        // second request in the middle of the loop
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_done("test_busy_ignore", seen, cycles);
        if (seen) begin
            check_result("test_busy_ignore", mont_model(ra, rb, rm), result);
            // the second request was sampled 51 cycles after the first one
            check_bit("test_busy_ignore latency", 1'b1, (51 + cycles) <= max_latency);
            // long enough for a queued request to have finished
            check_quiet("test_busy_ignore", max_latency);
        end
        finish_test("test_busy_ignore", e0);
    endtask

    task automatic test_result_hold();
        int       e0;
        operand_t ra;
        operand_t rb;
        operand_t rm;
        operand_t exp;
        e0 = errors;
        random_case(ra, rb, rm);
        exp = mont_model(ra, rb, rm);
        run_op("test_result_hold", ra, rb, rm);
        repeat (20) begin
            random_case(ra, rb, rm);
            @(posedge clk);
            a <= ra;
            b <= rb;
            m <= rm;
            @(negedge clk);
            check_result("test_result_hold", exp, result);
        end
        finish_test("test_result_hold", e0);
    endtask

    task automatic test_reset_abort();
        int       e0;
        operand_t ra;
        operand_t rb;
        operand_t rm;
        e0 = errors;
        random_case(ra, rb, rm);
        start_op(ra, rb, rm);
        repeat (100) @(posedge clk);
        resetn <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("test_reset_abort busy", 1'b0, busy);
        check_bit("test_reset_abort done", 1'b0, done);
        @(posedge clk);
        resetn <= 1'b1;
        random_case(ra, rb, rm);
        run_op("test_reset_abort", ra, rb, rm);
        finish_test("test_reset_abort", e0);
    endtask

    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        m      = '0;
        lfsr_q = 32'd96;
        errors = 0;
        checks = 0;
        tests  = 0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        test_small();
        test_zero();
        test_random();
        test_busy_ignore();
        test_result_hold();
        test_reset_abort();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
